//--- rtl/alu_pkg.sv
// ALU dispatcher shared types
package alu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  localparam int XLEN          = 32;
  localparam int PC_SIZE       = 32;
  localparam int RFIDX_WIDTH   = 5;
  localparam int CSR_IDX_WIDTH = 12;

  ////////////////////////////////////////////////////////////
  // Decode encodings
  typedef enum logic [1:0] {
    GRP_ALU,
    GRP_BJP,
    GRP_CSR
  } grp_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_OR,
    ALU_AND, ALU_SLT, ALU_SLTU, ALU_LUI, ALU_ECALL, ALU_EBREAK, ALU_WFI
  } alu_fn_e;

  typedef enum logic [3:0] {
    BJP_JAL, BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU,
    BJP_MRET, BJP_DRET, BJP_FENCEI
  } bjp_fn_e;

  typedef enum logic [1:0] {
    CSRRW,
    CSRRS,
    CSRRC
  } csr_fn_e;

  typedef struct packed {
    grp_e       grp;
    logic [3:0] fn;       // Read through the enum of grp
    logic       rv32;     // 4-byte instruction, else 2
    logic       op2_imm;  // Second operand from immediate
    logic       bjp_prdt; // Predicted taken
    logic       rs1_x0;   // Source register is x0
    logic [1:0] spare;
  } dec_info_t;

  typedef struct packed {
    logic excp;
    logic alu;
    logic bjp;
    logic csr;
  } unit_sel_t;

  ////////////////////////////////////////////////////////////
  // Shared datapath
  typedef enum logic [3:0] {
    DP_ADD, DP_SUB, DP_XOR, DP_SLL, DP_SRL, DP_SRA, DP_OR, DP_AND,
    DP_SLT, DP_SLTU, DP_PASS2, DP_CMP_EQ, DP_CMP_LT, DP_CMP_LTU
  } dpath_fn_e;

  typedef struct packed {
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    dpath_fn_e       fn;
  } dpath_req_t;

  typedef struct packed {
    logic [XLEN-1:0] res;
    logic            cmp;
  } dpath_rsp_t;

  typedef struct packed {
    logic [XLEN-1:0] wdat;
    logic            err;
  } unit_rsp_t;

  typedef struct packed {
    logic       bjp;
    logic       mret;
    logic       dret;
    logic       fencei;
    logic       prdt;
    logic       rslv;
    logic       ecall;
    logic       ebreak;
    logic       wfi;
    logic       ifu_misalgn;
    logic       ifu_buserr;
    logic       ifu_ilegl;
    logic [2:0] rsvd;  // Always zero
  } cmt_flags_t;

endpackage

//--- rtl/alu_dispatch.sv
// Instruction group dispatch
`timescale 1ns/100ps

module alu_dispatch (
  input  logic                i_valid,
  input  alu_pkg::dec_info_t  i_info,
  input  logic                i_ilegl,
  input  logic                i_buserr,
  input  logic                i_misalgn,
  output alu_pkg::unit_sel_t  o_sel,
  output logic                o_csr_valid
);
  import alu_pkg::*;

  logic excp_op;
  grp_e grp;

  // Any fetch fault wins over the decoded group
  assign excp_op = i_ilegl | i_buserr | i_misalgn;
  assign grp     = i_info.grp;

  assign o_sel.excp = excp_op;
  assign o_sel.alu  = ~excp_op & (grp == GRP_ALU);
  assign o_sel.bjp  = ~excp_op & (grp == GRP_BJP);
  assign o_sel.csr  = ~excp_op & (grp == GRP_CSR);

  assign o_csr_valid = i_valid & o_sel.csr;  // Only CSR needs its own valid

endmodule

//--- rtl/alu_rglr.sv
// Regular ALU decode
`timescale 1ns/100ps

module alu_rglr (
  input  logic [alu_pkg::XLEN-1:0] i_rs1,
  input  logic [alu_pkg::XLEN-1:0] i_rs2,
  input  logic [alu_pkg::XLEN-1:0] i_imm,
  input  alu_pkg::dec_info_t       i_info,
  output alu_pkg::dpath_req_t      o_req,
  output alu_pkg::cmt_flags_t      o_flags
);
  import alu_pkg::*;

  alu_fn_e fn;

  assign fn = alu_fn_e'(i_info.fn);

  assign o_req.op1 = i_rs1;
  assign o_req.op2 = i_info.op2_imm ? i_imm : i_rs2;  // I-type or R-type

  ////////////////////////////////////////////////////////////
  // Function to datapath request
  always_comb begin
    case (fn)
      ALU_ADD:  o_req.fn = DP_ADD;
      ALU_SUB:  o_req.fn = DP_SUB;
      ALU_XOR:  o_req.fn = DP_XOR;
      ALU_SLL:  o_req.fn = DP_SLL;
      ALU_SRL:  o_req.fn = DP_SRL;
      ALU_SRA:  o_req.fn = DP_SRA;
      ALU_OR:   o_req.fn = DP_OR;
      ALU_AND:  o_req.fn = DP_AND;
      ALU_SLT:  o_req.fn = DP_SLT;
      ALU_SLTU: o_req.fn = DP_SLTU;
      ALU_LUI:  o_req.fn = DP_PASS2;  // Upper immediate already formed
      default:  o_req.fn = DP_ADD;    // System ops, result unused
    endcase
  end

  ////////////////////////////////////////////////////////////
  // System commit flags
  always_comb begin
    o_flags        = '0;
    o_flags.ecall  = (fn == ALU_ECALL);
    o_flags.ebreak = (fn == ALU_EBREAK);
    o_flags.wfi    = (fn == ALU_WFI);
  end

endmodule

//--- rtl/alu_bjp.sv
// Branch and jump resolution
`timescale 1ns/100ps

module alu_bjp (
  input  logic [alu_pkg::XLEN-1:0] i_rs1,
  input  logic [alu_pkg::XLEN-1:0] i_rs2,
  input  logic [alu_pkg::XLEN-1:0] i_pc,
  input  alu_pkg::dec_info_t       i_info,
  input  alu_pkg::dpath_rsp_t      i_dp_rsp,
  output alu_pkg::dpath_req_t      o_req,
  output alu_pkg::unit_rsp_t       o_rsp,
  output alu_pkg::cmt_flags_t      o_flags
);
  import alu_pkg::*;

  bjp_fn_e         fn;
  logic            is_jump;
  logic            is_branch;
  logic            cmp_inv;  // Negated compare sense
  logic [XLEN-1:0] link_ofs;

  assign fn        = bjp_fn_e'(i_info.fn);
  assign is_jump   = (fn == BJP_JAL);
  assign is_branch = fn inside {BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU};
  assign cmp_inv   = fn inside {BJP_BNE, BJP_BGE, BJP_BGEU};

  // Compare request to the shared datapath
  assign o_req.op1 = i_rs1;
  assign o_req.op2 = i_rs2;
  always_comb begin
    case (fn)
      BJP_BLT, BJP_BGE:   o_req.fn = DP_CMP_LT;
      BJP_BLTU, BJP_BGEU: o_req.fn = DP_CMP_LTU;
      default:            o_req.fn = DP_CMP_EQ;
    endcase
  end

  // Link address has its own adder
  assign link_ofs   = i_info.rv32 ? XLEN'(4) : XLEN'(2);
  assign o_rsp.wdat = i_pc + link_ofs;
  assign o_rsp.err  = 1'b0;

  always_comb begin
    o_flags        = '0;
    o_flags.bjp    = is_jump | is_branch;
    o_flags.mret   = (fn == BJP_MRET);
    o_flags.dret   = (fn == BJP_DRET);
    o_flags.fencei = (fn == BJP_FENCEI);
    o_flags.prdt   = i_info.bjp_prdt;
    o_flags.rslv   = is_jump | (is_branch & (i_dp_rsp.cmp ^ cmp_inv));
  end

endmodule

//--- rtl/alu_csrctrl.sv
// CSR access control
`timescale 1ns/100ps

module alu_csrctrl (
  input  logic                              i_valid,
  input  logic                              i_ready,
  input  logic [alu_pkg::XLEN-1:0]          i_rs1,
  input  logic [alu_pkg::XLEN-1:0]          i_imm,
  input  alu_pkg::dec_info_t                i_info,
  input  logic                              i_rdwen,
  input  logic [alu_pkg::XLEN-1:0]          i_read_csr_dat,
  input  logic                              i_csr_access_ilgl,
  output logic                              o_csr_ena,
  output logic [alu_pkg::CSR_IDX_WIDTH-1:0] o_csr_idx,
  output logic                              o_csr_rd_en,
  output logic                              o_csr_wr_en,
  output logic [alu_pkg::XLEN-1:0]          o_wbck_csr_dat,
  output alu_pkg::unit_rsp_t                o_rsp
);
  import alu_pkg::*;

  csr_fn_e fn;
  logic    is_rw;

  assign fn    = csr_fn_e'(i_info.fn[1:0]);
  assign is_rw = (fn == CSRRW);

  // Access fires only on the accepting cycle of a legal access
  assign o_csr_ena   = i_valid & i_ready & ~i_csr_access_ilgl;
  assign o_csr_idx   = i_imm[CSR_IDX_WIDTH-1:0];
  assign o_csr_rd_en = is_rw ? i_rdwen : 1'b1;  // csrrw with rd=x0 skips the read
  assign o_csr_wr_en = is_rw ? 1'b1 : ~i_info.rs1_x0;

  always_comb begin
    case (fn)
      CSRRS:   o_wbck_csr_dat = i_read_csr_dat | i_rs1;   // Set bits
      CSRRC:   o_wbck_csr_dat = i_read_csr_dat & ~i_rs1;  // Clear bits
      default: o_wbck_csr_dat = i_rs1;
    endcase
  end

  assign o_rsp.wdat = i_read_csr_dat;
  assign o_rsp.err  = i_csr_access_ilgl;

endmodule

//--- rtl/alu_dpath.sv
// Shared ALU datapath
`timescale 1ns/100ps

module alu_dpath (
  input  alu_pkg::unit_sel_t  i_sel,
  input  alu_pkg::dpath_req_t i_alu_req,
  input  alu_pkg::dpath_req_t i_bjp_req,
  output alu_pkg::dpath_rsp_t o_rsp
);
  import alu_pkg::*;

  dpath_req_t      req;
  logic            op_sub;
  logic            op_unsigned;
  logic [XLEN:0]   add_a;
  logic [XLEN:0]   add_b;
  logic [XLEN:0]   add_sum;
  logic [XLEN-1:0] xor_res;
  logic [4:0]      shamt;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic            cmp_eq;
  logic            cmp_lt;

  assign req = i_sel.bjp ? i_bjp_req : i_alu_req;  // Only one requester at a time

  ////////////////////////////////////////////////////////////
  // 33-bit adder so one subtract serves both compares
  assign op_sub      = req.fn inside {DP_SUB, DP_SLT, DP_SLTU, DP_CMP_LT, DP_CMP_LTU};
  assign op_unsigned = req.fn inside {DP_SLTU, DP_CMP_LTU};

  assign add_a   = {~op_unsigned & req.op1[XLEN-1], req.op1};  // Sign or zero extend
  assign add_b   = {~op_unsigned & req.op2[XLEN-1], req.op2};
  assign add_sum = add_a + (op_sub ? ~add_b : add_b) + {{XLEN{1'b0}}, op_sub};

  // Top bit of the 33-bit difference is the sign
  assign cmp_lt = add_sum[XLEN];

  ////////////////////////////////////////////////////////////
  // Logic unit and shifter
  assign xor_res = req.op1 ^ req.op2;
  assign cmp_eq  = ~|xor_res;  // Equality reuses the XOR

  assign shamt   = req.op2[4:0];
  assign sll_res = req.op1 << shamt;
  assign srl_res = req.op1 >> shamt;
  assign sra_res = $signed(req.op1) >>> shamt;

  ////////////////////////////////////////////////////////////
  // Result select
  always_comb begin
    o_rsp.res = add_sum[XLEN-1:0];
    o_rsp.cmp = 1'b0;
    case (req.fn)
      DP_XOR:   o_rsp.res = xor_res;
      DP_SLL:   o_rsp.res = sll_res;
      DP_SRL:   o_rsp.res = srl_res;
      DP_SRA:   o_rsp.res = sra_res;
      DP_OR:    o_rsp.res = req.op1 | req.op2;
      DP_AND:   o_rsp.res = req.op1 & req.op2;
      DP_PASS2: o_rsp.res = req.op2;
      DP_SLT, DP_SLTU, DP_CMP_LT, DP_CMP_LTU: begin
        o_rsp.res = XLEN'(cmp_lt);  // Zero-extended flag
        o_rsp.cmp = cmp_lt;
      end
      DP_CMP_EQ: begin
        o_rsp.res = XLEN'(cmp_eq);
        o_rsp.cmp = cmp_eq;
      end
      default: ;  // Add and sub keep the sum
    endcase
  end

endmodule

//--- rtl/alu_result_arb.sv
// Result arbitration and commit handshake
`timescale 1ns/100ps

module alu_result_arb (
  input  logic                     i_valid,
  input  alu_pkg::unit_sel_t       i_sel,
  input  logic [alu_pkg::XLEN-1:0] i_alu_res,
  input  alu_pkg::unit_rsp_t       i_bjp_rsp,
  input  alu_pkg::unit_rsp_t       i_csr_rsp,
  input  alu_pkg::cmt_flags_t      i_alu_flags,
  input  alu_pkg::cmt_flags_t      i_bjp_flags,
  input  logic                     i_ilegl,
  input  logic                     i_buserr,
  input  logic                     i_misalgn,
  input  logic                     i_rdwen,
  input  logic                     i_cmt_ready,
  input  logic                     i_wbck_ready,
  output logic                     o_ready,
  output logic                     o_cmt_valid,
  output logic                     o_wbck_valid,
  output logic [alu_pkg::XLEN-1:0] o_wbck_wdat,
  output alu_pkg::cmt_flags_t      o_cmt_flags
);
  import alu_pkg::*;

  logic sel_err;
  logic need_wbck;

  ////////////////////////////////////////////////////////////
  // AND-OR result select
  // A fetch fault selects no unit and leaves the result zero
  assign o_wbck_wdat = ({XLEN{i_sel.alu}} & i_alu_res)
                     | ({XLEN{i_sel.bjp}} & i_bjp_rsp.wdat)
                     | ({XLEN{i_sel.csr}} & i_csr_rsp.wdat);

  assign sel_err = (i_sel.bjp & i_bjp_rsp.err)
                 | (i_sel.csr & i_csr_rsp.err)
                 | i_sel.excp;  // Fetch faults always count as errors

  ////////////////////////////////////////////////////////////
  // Coupled commit and write-back
  assign need_wbck = i_rdwen & ~sel_err;

  assign o_cmt_valid  = i_valid & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = need_wbck & i_valid & i_cmt_ready;
  assign o_ready      = i_cmt_ready & (~need_wbck | i_wbck_ready);

  // Each unit drives only its own flag fields
  always_comb begin
    o_cmt_flags = ({$bits(cmt_flags_t){i_sel.alu}} & i_alu_flags)
                | ({$bits(cmt_flags_t){i_sel.bjp}} & i_bjp_flags);
    o_cmt_flags.ifu_misalgn = i_misalgn;
    o_cmt_flags.ifu_buserr  = i_buserr;
    o_cmt_flags.ifu_ilegl   = i_ilegl | (i_sel.csr & i_csr_rsp.err);  // CSR fault reported as illegal
    o_cmt_flags.rsvd        = '0;
  end

endmodule

//--- rtl/exu_alu.sv
// Execution stage ALU top
`timescale 1ns/100ps

module exu_alu (
  input  logic                              i_valid,
  input  logic [alu_pkg::XLEN-1:0]          i_rs1,
  input  logic [alu_pkg::XLEN-1:0]          i_rs2,
  input  logic [alu_pkg::XLEN-1:0]          i_imm,
  input  logic [alu_pkg::PC_SIZE-1:0]       i_pc,
  input  alu_pkg::dec_info_t                i_info,
  input  logic [alu_pkg::RFIDX_WIDTH-1:0]   i_rdidx,
  input  logic                              i_rdwen,
  input  logic                              i_ilegl,
  input  logic                              i_buserr,
  input  logic                              i_misalgn,
  input  logic                              i_cmt_ready,
  input  logic                              i_wbck_ready,
  input  logic [alu_pkg::XLEN-1:0]          i_read_csr_dat,
  input  logic                              i_csr_access_ilgl,
  output logic                              o_ready,
  output logic                              o_cmt_valid,
  output logic                              o_wbck_valid,
  output logic [alu_pkg::XLEN-1:0]          o_wbck_wdat,
  output logic [alu_pkg::RFIDX_WIDTH-1:0]   o_wbck_rdidx,
  output logic [alu_pkg::PC_SIZE-1:0]       o_cmt_pc,
  output logic [alu_pkg::XLEN-1:0]          o_cmt_imm,
  output logic                              o_cmt_rv32,
  output alu_pkg::cmt_flags_t               o_cmt_flags,
  output logic                              o_csr_ena,
  output logic [alu_pkg::CSR_IDX_WIDTH-1:0] o_csr_idx,
  output logic                              o_csr_rd_en,
  output logic                              o_csr_wr_en,
  output logic [alu_pkg::XLEN-1:0]          o_wbck_csr_dat
);
  import alu_pkg::*;

  unit_sel_t  sel;
  logic       csr_valid;
  dpath_req_t alu_req;
  dpath_req_t bjp_req;
  dpath_rsp_t dp_rsp;
  unit_rsp_t  bjp_rsp;
  unit_rsp_t  csr_rsp;
  cmt_flags_t alu_flags;
  cmt_flags_t bjp_flags;

  // Commit side fields straight from the issue port
  assign o_wbck_rdidx = i_rdidx;
  assign o_cmt_pc     = i_pc;
  assign o_cmt_imm    = i_imm;
  assign o_cmt_rv32   = i_info.rv32;

  ////////////////////////////////////////////////////////////
  // Dispatch and units
  alu_dispatch u_dispatch (
    .i_valid     (i_valid),
    .i_info      (i_info),
    .i_ilegl     (i_ilegl),
    .i_buserr    (i_buserr),
    .i_misalgn   (i_misalgn),
    .o_sel       (sel),
    .o_csr_valid (csr_valid)
  );

  alu_rglr u_rglr (
    .i_rs1   (i_rs1),
    .i_rs2   (i_rs2),
    .i_imm   (i_imm),
    .i_info  (i_info),
    .o_req   (alu_req),
    .o_flags (alu_flags)
  );

  alu_bjp u_bjp (
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .i_pc     (i_pc),
    .i_info   (i_info),
    .i_dp_rsp (dp_rsp),
    .o_req    (bjp_req),
    .o_rsp    (bjp_rsp),
    .o_flags  (bjp_flags)
  );

  alu_csrctrl u_csrctrl (
    .i_valid           (csr_valid),
    .i_ready           (o_ready),
    .i_rs1             (i_rs1),
    .i_imm             (i_imm),
    .i_info            (i_info),
    .i_rdwen           (i_rdwen),
    .i_read_csr_dat    (i_read_csr_dat),
    .i_csr_access_ilgl (i_csr_access_ilgl),
    .o_csr_ena         (o_csr_ena),
    .o_csr_idx         (o_csr_idx),
    .o_csr_rd_en       (o_csr_rd_en),
    .o_csr_wr_en       (o_csr_wr_en),
    .o_wbck_csr_dat    (o_wbck_csr_dat),
    .o_rsp             (csr_rsp)
  );

  alu_dpath u_dpath (
    .i_sel     (sel),
    .i_alu_req (alu_req),
    .i_bjp_req (bjp_req),
    .o_rsp     (dp_rsp)
  );

  ////////////////////////////////////////////////////////////
  // Result and handshake
  alu_result_arb u_result_arb (
    .i_valid      (i_valid),
    .i_sel        (sel),
    .i_alu_res    (dp_rsp.res),
    .i_bjp_rsp    (bjp_rsp),
    .i_csr_rsp    (csr_rsp),
    .i_alu_flags  (alu_flags),
    .i_bjp_flags  (bjp_flags),
    .i_ilegl      (i_ilegl),
    .i_buserr     (i_buserr),
    .i_misalgn    (i_misalgn),
    .i_rdwen      (i_rdwen),
    .i_cmt_ready  (i_cmt_ready),
    .i_wbck_ready (i_wbck_ready),
    .o_ready      (o_ready),
    .o_cmt_valid  (o_cmt_valid),
    .o_wbck_valid (o_wbck_valid),
    .o_wbck_wdat  (o_wbck_wdat),
    .o_cmt_flags  (o_cmt_flags)
  );

endmodule

//--- tb/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);
  localparam int RST_CYCLES = 16;

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;  // 4 ns period
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

//--- tb/tb_exu_alu.sv
// ALU dispatcher testbench
`timescale 1ns/100ps

module tb_exu_alu;
  import alu_pkg::*;

  localparam int N_ALU       = 14 * 8;
  localparam int N_BJP       = 10 * 10;
  localparam int N_CSR       = 3 * 16;
  localparam int N_EXC       = 3 * 7;
  localparam int N_BP        = 200;
  localparam int CYCLE_LIMIT = 16 + N_ALU + N_BJP + N_CSR + N_EXC + N_BP + 64;

  typedef struct packed {
    logic        valid;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    logic [31:0] pc;
    dec_info_t   info;
    logic [4:0]  rdidx;
    logic        rdwen;
    logic        ilegl;
    logic        buserr;
    logic        misalgn;
    logic        cmt_ready;
    logic        wbck_ready;
    logic [31:0] csr_rdat;
    logic        csr_ilgl;
  } stim_t;

  typedef struct packed {
    logic        ready;
    logic        cmt_valid;
    logic        wbck_valid;
    logic [31:0] wdat;
    cmt_flags_t  flags;
    logic        csr_ena;
    logic [11:0] csr_idx;
    logic        csr_rd_en;
    logic        csr_wr_en;
    logic [31:0] csr_dat;
  } exp_t;

  logic        clk;
  logic        rst_n;
  stim_t       stim;
  exp_t        expd;
  logic        o_ready;
  logic        o_cmt_valid;
  logic        o_wbck_valid;
  logic [31:0] o_wbck_wdat;
  logic [4:0]  o_wbck_rdidx;
  logic [31:0] o_cmt_pc;
  logic [31:0] o_cmt_imm;
  logic        o_cmt_rv32;
  cmt_flags_t  o_cmt_flags;
  logic        o_csr_ena;
  logic [11:0] o_csr_idx;
  logic        o_csr_rd_en;
  logic        o_csr_wr_en;
  logic [31:0] o_wbck_csr_dat;

  logic [31:0] lfsr_state = 32'h5bc95bba;
  logic [31:0] edge_a [6];
  logic [31:0] edge_b [6];
  int          n_checks  = 0;
  int          n_errors  = 0;
  int          n_tests   = 0;
  int          chk_base  = 0;
  int          err_base  = 0;
  int          cycle_cnt = 0;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

  exu_alu i_dut (
    .i_valid           (stim.valid),
    .i_rs1             (stim.rs1),
    .i_rs2             (stim.rs2),
    .i_imm             (stim.imm),
    .i_pc              (stim.pc),
    .i_info            (stim.info),
    .i_rdidx           (stim.rdidx),
    .i_rdwen           (stim.rdwen),
    .i_ilegl           (stim.ilegl),
    .i_buserr          (stim.buserr),
    .i_misalgn         (stim.misalgn),
    .i_cmt_ready       (stim.cmt_ready),
    .i_wbck_ready      (stim.wbck_ready),
    .i_read_csr_dat    (stim.csr_rdat),
    .i_csr_access_ilgl (stim.csr_ilgl),
    .o_ready           (o_ready),
    .o_cmt_valid       (o_cmt_valid),
    .o_wbck_valid      (o_wbck_valid),
    .o_wbck_wdat       (o_wbck_wdat),
    .o_wbck_rdidx      (o_wbck_rdidx),
    .o_cmt_pc          (o_cmt_pc),
    .o_cmt_imm         (o_cmt_imm),
    .o_cmt_rv32        (o_cmt_rv32),
    .o_cmt_flags       (o_cmt_flags),
    .o_csr_ena         (o_csr_ena),
    .o_csr_idx         (o_csr_idx),
    .o_csr_rd_en       (o_csr_rd_en),
    .o_csr_wr_en       (o_csr_wr_en),
    .o_wbck_csr_dat    (o_wbck_csr_dat)
  );

  ////////////////////////////////////////////////////////////
  // Galois LFSR stepped once per random bit
  function automatic logic rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'h80200003;  // x^32+x^22+x^2+x+1
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) v = {v[30:0], rand_bit()};
    return v;
  endfunction

  function automatic stim_t base_stim(input grp_e g, input logic [3:0] fn);
    stim_t s;
    s               = '0;
    s.valid         = 1'b1;
    s.rs1           = rand_bits(32);
    s.rs2           = rand_bits(32);
    s.imm           = rand_bits(32);
    s.pc            = rand_bits(32) & 32'hffff_fffe;
    s.rdidx         = 5'(rand_bits(5));
    s.rdwen         = rand_bit();
    s.cmt_ready     = rand_bit();
    s.wbck_ready    = rand_bit();
    s.csr_rdat      = rand_bits(32);
    s.info.grp      = g;
    s.info.fn       = fn;
    s.info.rv32     = rand_bit();
    s.info.op2_imm  = rand_bit();
    s.info.bjp_prdt = rand_bit();
    s.info.rs1_x0   = rand_bit();
    return s;
  endfunction

  // Legal function code for a random group
  function automatic stim_t random_instr();
    int         g;
    logic [3:0] fn;
    g = rand_bits(2) % 3;
    case (g)
      0:       fn = 4'(rand_bits(4) % 14);
      1:       fn = 4'(rand_bits(4) % 10);
      default: fn = 4'(rand_bits(2) % 3);
    endcase
    return base_stim(grp_e'(g), fn);
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model of the dispatcher
  function automatic exp_t ref_model(input stim_t s);
    exp_t        e;
    logic        excp;
    logic        err;
    logic        need;
    logic        taken;
    logic [31:0] op2;
    logic [4:0]  sh;
    e     = '0;
    taken = 1'b0;
    excp  = s.ilegl | s.buserr | s.misalgn;
    err   = excp;
    op2   = s.info.op2_imm ? s.imm : s.rs2;
    sh    = op2[4:0];
    e.flags.ifu_misalgn = s.misalgn;
    e.flags.ifu_buserr  = s.buserr;
    e.flags.ifu_ilegl   = s.ilegl;

    e.csr_idx = s.imm[11:0];
    case (s.info.fn[1:0])
      CSRRW: begin
        e.csr_rd_en = s.rdwen;
        e.csr_wr_en = 1'b1;
        e.csr_dat   = s.rs1;
      end
      CSRRS: begin
        e.csr_rd_en = 1'b1;
        e.csr_wr_en = ~s.info.rs1_x0;
        e.csr_dat   = s.csr_rdat | s.rs1;
      end
      default: begin
        e.csr_rd_en = 1'b1;
        e.csr_wr_en = ~s.info.rs1_x0;
        e.csr_dat   = s.csr_rdat & ~s.rs1;
      end
    endcase

    if (excp) begin
      e.wdat = '0;
    end else if (s.info.grp == GRP_ALU) begin
      case (s.info.fn)
        ALU_SUB:  e.wdat = s.rs1 - op2;
        ALU_XOR:  e.wdat = s.rs1 ^ op2;
        ALU_SLL:  e.wdat = s.rs1 << sh;
        ALU_SRL:  e.wdat = s.rs1 >> sh;
        ALU_SRA:  e.wdat = $unsigned($signed(s.rs1) >>> sh);
        ALU_OR:   e.wdat = s.rs1 | op2;
        ALU_AND:  e.wdat = s.rs1 & op2;
        ALU_SLT:  e.wdat = {31'b0, $signed(s.rs1) < $signed(op2)};
        ALU_SLTU: e.wdat = {31'b0, s.rs1 < op2};
        ALU_LUI:  e.wdat = op2;
        default:  e.wdat = s.rs1 + op2;  // Add and the system ops
      endcase
      e.flags.ecall  = (s.info.fn == ALU_ECALL);
      e.flags.ebreak = (s.info.fn == ALU_EBREAK);
      e.flags.wfi    = (s.info.fn == ALU_WFI);
    end else if (s.info.grp == GRP_BJP) begin
      e.wdat = s.pc + (s.info.rv32 ? 32'd4 : 32'd2);  // Link address
      case (s.info.fn)
        BJP_JAL:    taken = 1'b1;
        BJP_BEQ:    taken = (s.rs1 == s.rs2);
        BJP_BNE:    taken = (s.rs1 != s.rs2);
        BJP_BLT:    taken = ($signed(s.rs1) < $signed(s.rs2));
        BJP_BGE:    taken = ($signed(s.rs1) >= $signed(s.rs2));
        BJP_BLTU:   taken = (s.rs1 < s.rs2);
        BJP_BGEU:   taken = (s.rs1 >= s.rs2);
        BJP_MRET:   e.flags.mret = 1'b1;
        BJP_DRET:   e.flags.dret = 1'b1;
        BJP_FENCEI: e.flags.fencei = 1'b1;
        default:    taken = 1'b0;
      endcase
      e.flags.bjp  = (s.info.fn <= BJP_BGEU);
      e.flags.rslv = taken;
      e.flags.prdt = s.info.bjp_prdt;
    end else begin
      e.wdat = s.csr_rdat;
      err    = s.csr_ilgl;
      e.flags.ifu_ilegl = s.ilegl | s.csr_ilgl;
    end

    // Coupled commit and write-back
    need         = s.rdwen & ~err;
    e.cmt_valid  = s.valid & (~need | s.wbck_ready);
    e.wbck_valid = need & s.valid & s.cmt_ready;
    e.ready      = s.cmt_ready & (~need | s.wbck_ready);
    e.csr_ena    = s.valid & ~excp & (s.info.grp == GRP_CSR) & e.ready & ~s.csr_ilgl;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking
  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      n_errors++;
    end
  endtask

  // Outputs settle after the rising edge, so sample on the falling one
  always @(negedge clk) begin
    if (rst_n) begin
      expd = ref_model(stim);
      check_field("o_ready", o_ready, expd.ready);
      check_field("o_cmt_valid", o_cmt_valid, expd.cmt_valid);
      check_field("o_wbck_valid", o_wbck_valid, expd.wbck_valid);
      check_field("o_wbck_wdat", o_wbck_wdat, expd.wdat);
      check_field("o_cmt_flags", o_cmt_flags, expd.flags);
      check_field("o_csr_ena", o_csr_ena, expd.csr_ena);
      check_field("o_wbck_rdidx", o_wbck_rdidx, stim.rdidx);
      check_field("o_cmt_pc", o_cmt_pc, stim.pc);
      check_field("o_cmt_imm", o_cmt_imm, stim.imm);
      check_field("o_cmt_rv32", o_cmt_rv32, stim.info.rv32);
      if (stim.info.grp == GRP_CSR) begin
        check_field("o_csr_idx", o_csr_idx, expd.csr_idx);
        check_field("o_csr_rd_en", o_csr_rd_en, expd.csr_rd_en);
        check_field("o_csr_wr_en", o_csr_wr_en, expd.csr_wr_en);
        check_field("o_wbck_csr_dat", o_wbck_csr_dat, expd.csr_dat);
      end
      n_checks++;
      assert (!(o_wbck_valid && !stim.rdwen)) else begin
        $display("Write-back valid raised for an instruction with rdwen low at %0t", $time);
        n_errors++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  task automatic drive(input stim_t s);
    @(posedge clk);
    stim <= s;
  endtask

  task automatic end_test(input string name);
    @(posedge clk);  // Last vector checked on the falling edge before this
    n_tests++;
    $display("Test %0d %s: %0d checks, %0d errors", n_tests, name,
             n_checks - chk_base, n_errors - err_base);
    chk_base = n_checks;
    err_base = n_errors;
  endtask

  initial begin
    stim_t s;
    int    fn;
    int    k;
    int    m;
    int    n_accept;
    stim   = '0;  // Valid low through reset
    edge_a = '{32'h0, 32'h80000000, 32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h0};
    edge_b = '{32'h0, 32'h80000000, 32'h80000000, 32'h7fffffff, 32'h0, 32'hffffffff};
    while (!rst_n) @(posedge clk);

    for (fn = 0; fn < 14; fn++) begin
      for (k = 0; k < 8; k++) begin
        s = base_stim(GRP_ALU, 4'(fn));
        s.info.op2_imm = k[0];  // Register and immediate operand
        drive(s);
      end
    end
    end_test("regular ALU");

    for (fn = 0; fn < 10; fn++) begin
      for (k = 0; k < 10; k++) begin
        s = base_stim(GRP_BJP, 4'(fn));
        if (k < 6) begin
          s.rs1 = edge_a[k];
          s.rs2 = edge_b[k];
        end else if (k == 6) begin
          s.rs2 = s.rs1;
        end
        s.info.rv32 = k[0];
        drive(s);
      end
    end
    end_test("branch and jump");

    for (fn = 0; fn < 3; fn++) begin
      for (m = 0; m < 16; m++) begin
        s = base_stim(GRP_CSR, 4'(fn));
        s.info.rs1_x0 = m[0];
        s.rdwen       = m[1];
        s.csr_ilgl    = m[2];
        drive(s);
      end
    end
    end_test("CSR access");

    // Every fault mask against every group
    for (k = 0; k < 3; k++) begin
      for (m = 1; m < 8; m++) begin
        s = random_instr();
        s.info.grp = grp_e'(k);
        s.info.fn  = (k == 2) ? 4'(rand_bits(2) % 3)
                              : 4'(rand_bits(4) % ((k == 0) ? 14 : 10));
        s.misalgn  = m[0];
        s.buserr   = m[1];
        s.ilegl    = m[2];
        s.rdwen    = 1'b1;
        drive(s);
      end
    end
    end_test("fetch exceptions");

    // Instruction held until the handshake accepts it
    n_accept = 0;
    s = random_instr();
    repeat (N_BP) begin
      @(posedge clk);
      if (o_ready && stim.valid) begin
        n_accept++;
        s = random_instr();
        s.csr_ilgl = rand_bit();
      end
      s.cmt_ready  = rand_bit();
      s.wbck_ready = rand_bit();
      stim <= s;
    end
    end_test($sformatf("back-pressure (%0d accepted)", n_accept));

    $display("Totals: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
rtl/alu_pkg.sv
rtl/alu_dispatch.sv
rtl/alu_rglr.sv
rtl/alu_bjp.sv
rtl/alu_csrctrl.sv
rtl/alu_dpath.sv
rtl/alu_result_arb.sv
rtl/exu_alu.sv
tb/tb_clk_gen.sv
tb/tb_exu_alu.sv

//--- Bender.yml
package:
  name: exu_alu

sources:
  - rtl/alu_pkg.sv
  - rtl/alu_dispatch.sv
  - rtl/alu_rglr.sv
  - rtl/alu_bjp.sv
  - rtl/alu_csrctrl.sv
  - rtl/alu_dpath.sv
  - rtl/alu_result_arb.sv
  - rtl/exu_alu.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_exu_alu.sv
